// File: source/llc_geom_pkg.sv
// geometry of the direct mapped cache and the field layout of an address
package llc_geom_pkg;

  localparam int unsigned AddrWidth        = 32;
  localparam int unsigned DataWidth        = 32;
  localparam int unsigned NoLines          = 64;  // one word per line
  localparam int unsigned ByteOffsetLength = 2;   // word aligned accesses
  localparam int unsigned IndexLength      = $clog2(NoLines);
  localparam int unsigned TagLength        = AddrWidth - IndexLength - ByteOffsetLength;

  // bit positions of the address fields, low bits up
  localparam int unsigned IndexLsb = ByteOffsetLength;
  localparam int unsigned TagLsb   = IndexLsb + IndexLength;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [IndexLength-1:0] index_t;
  typedef logic [TagLength-1:0]   tag_t;

endpackage

// File: source/llc_map_pkg.sv
// address map with the bounds of the cacheable ram window
package llc_map_pkg;

  // window is [RamStartAddr, RamEndAddr)
  localparam llc_geom_pkg::addr_t RamStartAddr = 32'h0000_0000;
  localparam llc_geom_pkg::addr_t RamEndAddr   = 32'h0001_0000;  // first uncached address

endpackage

// File: source/llc_tag_store.sv
// tag and valid array with registered lookup and hit compare
`timescale 1ns/1ps

module llc_tag_store (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                lookup_i,       // start a lookup
  input  llc_geom_pkg::addr_t lookup_addr_i,
  input  logic                fill_i,         // write tag and set valid
  input  llc_geom_pkg::addr_t fill_addr_i,
  output logic                hit_o           // one cycle after lookup_i
);
  import llc_geom_pkg::*;

  tag_t               tag_mem [NoLines];
  logic [NoLines-1:0] valid_q;

  index_t lkp_index_q;  // captured lookup fields
  tag_t   lkp_tag_q;
  index_t fill_index;

  assign fill_index = fill_addr_i[IndexLsb +: IndexLength];

  // one valid bit per line, set by a fill
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_mem[fill_index] <= fill_addr_i[TagLsb +: TagLength];
    end
    if (lookup_i) begin
      lkp_index_q <= lookup_addr_i[IndexLsb +: IndexLength];
      lkp_tag_q   <= lookup_addr_i[TagLsb +: TagLength];
    end
  end

  // compare against the stored line selected by the captured index
  assign hit_o = valid_q[lkp_index_q] && (tag_mem[lkp_index_q] == lkp_tag_q);

  // the controller must keep fills out of a lookup slot
  a_no_fill_on_lookup : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(fill_i && lookup_i)
  ) else $error("tag store got a fill and a lookup on the same edge");

endmodule

// File: source/llc_data_store.sv
// data word array with registered read and single word write
`timescale 1ns/1ps

module llc_data_store (
  input  logic                clk_i,
  input  logic                lookup_i,       // registered read at the index
  input  llc_geom_pkg::addr_t lookup_addr_i,
  input  logic                fill_i,         // write one word
  input  llc_geom_pkg::addr_t fill_addr_i,
  input  llc_geom_pkg::data_t fill_data_i,
  output llc_geom_pkg::data_t rdata_o         // one cycle after lookup_i
);
  import llc_geom_pkg::*;

  data_t  data_mem [NoLines];
  data_t  rdata_q;
  index_t lookup_index;
  index_t fill_index;

  assign lookup_index = lookup_addr_i[IndexLsb +: IndexLength];
  assign fill_index   = fill_addr_i[IndexLsb +: IndexLength];

  // write port
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      data_mem[fill_index] <= fill_data_i;
    end
  end

  // read port
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      rdata_q <= data_mem[lookup_index];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: source/llc_ctrl.sv
// cache controller with request handshake, bypass decision, hit/miss handling and wishbone master
`timescale 1ns/1ps

module llc_ctrl (
  input  logic                clk_i,
  input  logic                reset_i,
  // cpu request
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                req_we_i,
  input  llc_geom_pkg::addr_t req_addr_i,
  input  llc_geom_pkg::data_t req_wdata_i,
  // cpu response
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output llc_geom_pkg::data_t rsp_rdata_o,
  // store lookup
  output logic                lookup_o,
  output llc_geom_pkg::addr_t lookup_addr_o,
  input  logic                hit_i,
  input  llc_geom_pkg::data_t rdata_i,
  // store fill
  output logic                fill_o,
  output llc_geom_pkg::addr_t fill_addr_o,
  output llc_geom_pkg::data_t fill_data_o,
  // wishbone classic master
  output logic                mem_cyc_o,
  output logic                mem_stb_o,
  output logic                mem_we_o,
  output llc_geom_pkg::addr_t mem_adr_o,
  output llc_geom_pkg::data_t mem_dat_o,
  input  logic                mem_ack_i,
  input  llc_geom_pkg::data_t mem_dat_i
);
  import llc_geom_pkg::*;
  import llc_map_pkg::*;

  enum logic [2:0] {
    StIdle,    // ready for a request
    StLookup,  // drive the lookup into both stores
    StCheck,   // store results are valid
    StMem,     // wishbone cycle open
    StResp     // response waiting for rsp_ready_i
  } state_q;

  // latched request
  addr_t addr_q;
  data_t wdata_q;
  logic  we_q;
  logic  cached_q;
  logic  hit_q;    // hit result kept for the write-through fill

  logic  rsp_valid_q;
  data_t rsp_rdata_q;
  logic  cyc_q;
  logic  stb_q;

  logic  req_cached;
  logic  req_accept;
  logic  mem_done;

  assign req_cached = (req_addr_i >= RamStartAddr) && (req_addr_i < RamEndAddr);
  assign req_ready_o = (state_q == StIdle);
  assign req_accept  = req_valid_i && req_ready_o;
  assign mem_done    = (state_q == StMem) && mem_ack_i;

  // control path
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= StIdle;
      rsp_valid_q <= 1'b0;
      cyc_q       <= 1'b0;
      stb_q       <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          if (req_valid_i) begin
            if (req_cached) begin
              state_q <= StLookup;
            end else begin
              // bypass goes straight to memory
              state_q <= StMem;
              cyc_q   <= 1'b1;
              stb_q   <= 1'b1;
            end
          end
        end
        StLookup: begin
          state_q <= StCheck;
        end
        StCheck: begin
          if (hit_i && !we_q) begin
            state_q     <= StResp;  // read hit is answered from the cache
            rsp_valid_q <= 1'b1;
          end else begin
            state_q <= StMem;       // read miss or write-through
            cyc_q   <= 1'b1;
            stb_q   <= 1'b1;
          end
        end
        StMem: begin
          if (mem_ack_i) begin
            state_q     <= StResp;
            cyc_q       <= 1'b0;    // cycle ends on the ack edge
            stb_q       <= 1'b0;
            rsp_valid_q <= 1'b1;
          end
        end
        StResp: begin
          if (rsp_ready_i) begin
            state_q     <= StIdle;
            rsp_valid_q <= 1'b0;
          end
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      addr_q   <= req_addr_i;
      wdata_q  <= req_wdata_i;
      we_q     <= req_we_i;
      cached_q <= req_cached;
    end
    if (state_q == StCheck) begin
      hit_q       <= hit_i;
      rsp_rdata_q <= rdata_i;
    end
    if (mem_done) begin
      rsp_rdata_q <= we_q ? '0 : mem_dat_i;  // writes answer with zero data
    end
  end

  assign lookup_o      = (state_q == StLookup);
  assign lookup_addr_o = addr_q;

  // cached read miss allocates and a cached write hit updates the line
  assign fill_o      = mem_done && cached_q && (!we_q || hit_q);
  assign fill_addr_o = addr_q;
  assign fill_data_o = we_q ? wdata_q : mem_dat_i;

  assign mem_cyc_o = cyc_q;
  assign mem_stb_o = stb_q;
  assign mem_we_o  = we_q;
  assign mem_adr_o = addr_q;
  assign mem_dat_o = wdata_q;

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;

  // response must hold while the cpu stalls
  a_rsp_stable : assert property (
    @(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o)
  ) else $error("response changed under back-pressure");

  // strobe stays up inside its cycle with a stable address until the ack
  a_stb_held : assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_stb_o && !mem_ack_i |=> mem_stb_o && mem_cyc_o && $stable(mem_adr_o)
  ) else $error("wishbone strobe dropped or address changed before the ack");

endmodule

// File: source/llc_top.sv
// top level of the direct mapped last-level cache with its stores and controller
`timescale 1ns/1ps

module llc_top (
  input  logic                clk_i,
  input  logic                reset_i,
  // cpu request
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                req_we_i,
  input  llc_geom_pkg::addr_t req_addr_i,
  input  llc_geom_pkg::data_t req_wdata_i,
  // cpu response
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output llc_geom_pkg::data_t rsp_rdata_o,
  // wishbone memory port
  output logic                mem_cyc_o,
  output logic                mem_stb_o,
  output logic                mem_we_o,
  output llc_geom_pkg::addr_t mem_adr_o,
  output llc_geom_pkg::data_t mem_dat_o,
  input  logic                mem_ack_i,
  input  llc_geom_pkg::data_t mem_dat_i
);
  import llc_geom_pkg::*;

  logic  lookup;
  addr_t lookup_addr;
  logic  fill;
  addr_t fill_addr;
  data_t fill_data;
  logic  hit;
  data_t rdata;

  // both stores see the same lookup and fill
  llc_tag_store u_tag_store (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .lookup_i      ( lookup      ),
    .lookup_addr_i ( lookup_addr ),
    .fill_i        ( fill        ),
    .fill_addr_i   ( fill_addr   ),
    .hit_o         ( hit         )
  );

  llc_data_store u_data_store (
    .clk_i         ( clk_i       ),
    .lookup_i      ( lookup      ),
    .lookup_addr_i ( lookup_addr ),
    .fill_i        ( fill        ),
    .fill_addr_i   ( fill_addr   ),
    .fill_data_i   ( fill_data   ),
    .rdata_o       ( rdata       )
  );

  llc_ctrl u_ctrl (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .req_valid_i   ( req_valid_i ),
    .req_ready_o   ( req_ready_o ),
    .req_we_i      ( req_we_i    ),
    .req_addr_i    ( req_addr_i  ),
    .req_wdata_i   ( req_wdata_i ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_ready_i   ( rsp_ready_i ),
    .rsp_rdata_o   ( rsp_rdata_o ),
    .lookup_o      ( lookup      ),
    .lookup_addr_o ( lookup_addr ),
    .hit_i         ( hit         ),
    .rdata_i       ( rdata       ),
    .fill_o        ( fill        ),
    .fill_addr_o   ( fill_addr   ),
    .fill_data_o   ( fill_data   ),
    .mem_cyc_o     ( mem_cyc_o   ),
    .mem_stb_o     ( mem_stb_o   ),
    .mem_we_o      ( mem_we_o    ),
    .mem_adr_o     ( mem_adr_o   ),
    .mem_dat_o     ( mem_dat_o   ),
    .mem_ack_i     ( mem_ack_i   ),
    .mem_dat_i     ( mem_dat_i   )
  );

endmodule

// File: verif/llc_tb_checks.svh
// compare tasks and the stop helper of the cache testbench, included into llc_tb
`ifndef LLC_TB_CHECKS_SVH
`define LLC_TB_CHECKS_SVH

  // print the reason, then end the run with a failing status
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  // response data of one request
  task automatic check_rdata(input data_t got, input data_t exp, input addr_t addr);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %t: response for %h is %h, expected %h",
                         $time, addr, got, exp));
    end
  endtask

  // address driven on the wishbone bus
  task automatic check_mem_addr(input addr_t got, input addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %t: memory cycle at %h, expected %h",
                         $time, got, exp));
    end
  endtask

`endif

// File: verif/llc_tb.sv
// testbench for the last-level cache, runs golden-file requests against a wishbone memory model
`timescale 1ns/1ps

module llc_tb;
  import llc_geom_pkg::*;
  import llc_map_pkg::*;

  localparam int ResetCycles = 8;
  localparam int CyclesPerOp = 50;  // watchdog budget per golden line

  logic  clk_i;
  logic  reset_i;
  logic  req_valid_i;
  logic  req_ready_o;
  logic  req_we_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  logic  rsp_valid_o;
  logic  rsp_ready_i;
  data_t rsp_rdata_o;
  logic  mem_cyc_o;
  logic  mem_stb_o;
  logic  mem_we_o;
  addr_t mem_adr_o;
  data_t mem_dat_o;
  logic  mem_ack_i;
  data_t mem_dat_i;

  // golden file columns
  logic [7:0] op_q [$];
  addr_t      addr_q [$];
  data_t      wdata_q [$];
  data_t      exp_q [$];
  int         mem_q [$];
  int         n_ops = 0;
  bit         loaded = 1'b0;

  int    seed = 82709;
  data_t mem_store [addr_t];  // words written through to memory
  addr_t cur_addr;            // request in flight
  logic  cur_we;
  int    mem_count;           // wishbone cycles seen for it

  llc_top dut (.*);

  always #5 clk_i = ~clk_i;

  `include "llc_tb_checks.svh"

  // unwritten words carry a pattern of their whole address
  function automatic data_t read_word(input addr_t addr);
    if (mem_store.exists(addr)) begin
      return mem_store[addr];
    end
    return addr ^ 32'hA5A5_0000;
  endfunction

  task automatic load_golden;
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    addr_t      a;
    data_t      wd;
    data_t      ex;
    int         m;
    fd = $fopen("verif/llc_golden.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open the golden file verif/llc_golden.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // blank or comment
      n = $sscanf(line, "%c %h %h %h %d", op, a, wd, ex, m);
      if (n != 5) begin
        stop_run($sformatf("golden line cannot be parsed: %s", line));
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      wdata_q.push_back(wd);
      exp_q.push_back(ex);
      mem_q.push_back(m);
    end
    $fclose(fd);
    n_ops  = op_q.size();
    loaded = 1'b1;
  endtask

  // one request from drive to response transfer, entered 1 ns after an edge
  task automatic run_request(input int i);
    int   cycles;
    int   latency;
    logic cached;
    logic valid_now;
    logic ready_now;
    logic done;
    cached    = (addr_q[i] >= RamStartAddr) && (addr_q[i] < RamEndAddr);
    cur_addr  = addr_q[i];
    cur_we    = (op_q[i] == "W");
    mem_count = 0;
    req_valid_i = 1'b1;
    req_we_i    = cur_we;
    req_addr_i  = addr_q[i];
    req_wdata_i = wdata_q[i];
    while (!req_ready_o) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);  // acceptance edge
    #1;
    req_valid_i = 1'b0;
    cycles  = 0;
    latency = -1;
    done    = 1'b0;
    while (!done) begin
      valid_now = rsp_valid_o;
      if (valid_now) begin
        if (latency < 0) latency = cycles;
        check_rdata(rsp_rdata_o, exp_q[i], addr_q[i]);  // also while stalled
      end
      rsp_ready_i = ($random(seed) & 3) != 0;  // random stalls
      ready_now   = rsp_ready_i;
      @(posedge clk_i);
      #1;
      cycles++;
      done = valid_now && ready_now;
    end
    rsp_ready_i = 1'b0;
    if (mem_count != mem_q[i]) begin
      stop_run($sformatf("request %0d at %h made %0d memory cycles, expected %0d",
                         i, addr_q[i], mem_count, mem_q[i]));
    end
    if (!cur_we && cached && mem_q[i] == 0 && latency != 2) begin
      stop_run($sformatf("read hit at %h answered after %0d cycles instead of 2",
                         addr_q[i], latency));
    end
  endtask

  // wishbone slave with an ack delay of 0 to 3 cycles
  initial begin : wb_slave
    int delay;
    mem_ack_i = 1'b0;
    mem_dat_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      mem_ack_i = 1'b0;
      // single accesses only, so cyc and stb rise and drop together
      if (mem_cyc_o !== mem_stb_o) begin
        stop_run("wishbone cyc and stb differ outside of a single access");
      end
      if (mem_cyc_o && mem_stb_o) begin
        delay = $random(seed) & 3;
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        mem_count++;
        check_mem_addr(mem_adr_o, cur_addr);
        if (mem_we_o !== cur_we) begin
          stop_run("memory cycle runs in the wrong direction for the request");
        end
        if (mem_we_o) begin
          mem_store[mem_adr_o] = mem_dat_o;
        end else begin
          mem_dat_i = read_word(mem_adr_o);
        end
        mem_ack_i = 1'b1;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (ResetCycles + n_ops * CyclesPerOp) @(posedge clk_i);
    stop_run("watchdog expired before all golden requests completed");
  end

  initial begin : main
    $timeformat(-9, 0, " ns", 0);
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b0;
    cur_addr    = '0;
    cur_we      = 1'b0;
    mem_count   = 0;
    load_golden();
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0 ||
        mem_cyc_o !== 1'b0 || mem_stb_o !== 1'b0) begin
      stop_run("outputs are not in their reset state after reset");
    end
    for (int i = 0; i < n_ops; i++) begin
      run_request(i);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: llc_top.f
+incdir+verif
source/llc_geom_pkg.sv
source/llc_map_pkg.sv
source/llc_tag_store.sv
source/llc_data_store.sv
source/llc_ctrl.sv
source/llc_top.sv
verif/llc_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = llc_tb
FILELIST = llc_top.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: verif/llc_golden.txt
# op addr wdata expected_rdata mem_access
# op is R or W, values in hex, mem_access is 1 when one wishbone cycle is expected
R 00000100 00000000 a5a50100 1
R 00000100 00000000 a5a50100 0
R 00000104 00000000 a5a50104 1
R 00000104 00000000 a5a50104 0
W 00000104 11112222 00000000 1
R 00000104 00000000 11112222 0
W 00000208 33334444 00000000 1
R 00000208 00000000 33334444 1
R 00000208 00000000 33334444 0
R 00010000 00000000 a5a40000 1
R 00010000 00000000 a5a40000 1
W 00010004 55556666 00000000 1
R 00010004 00000000 55556666 1
R 00010004 00000000 55556666 1
R 80000000 00000000 25a50000 1
R 00000200 00000000 a5a50200 1
R 00000100 00000000 a5a50100 1
R 00000200 00000000 a5a50200 1
W 00001104 77778888 00000000 1
R 00000104 00000000 11112222 0
R 00001104 00000000 77778888 1
R 00000104 00000000 11112222 1
R 0000fffc 00000000 a5a5fffc 1
R 0000fffc 00000000 a5a5fffc 0
W 0000fffc 9999aaaa 00000000 1
R 0000fffc 00000000 9999aaaa 0
R 00000200 00000000 a5a50200 0
R 00000208 00000000 33334444 0
